// ==== dv/pipe_cpu_stimulus.txt ====
# p <byte address> <instruction word>   program, hex
# w <register> <value>                  expected register write, program order, hex
p 00000000 3c011234  # lui   r1, 0x1234
p 00000004 34218765  # ori   r1, r1, 0x8765     dist 1
p 00000008 2402ffff  # addiu r2, r0, -1
p 0000000c 00221821  # addu  r3, r1, r2         dist 2 and 1
p 00000010 00612023  # subu  r4, r3, r1         dist 1 and 3
p 00000014 0080282a  # slt   r5, r4, r0
p 00000018 0081302b  # sltu  r6, r4, r1
p 0000001c 28870005  # slti  r7, r4, 5
p 00000020 30488f0f  # andi  r8, r2, 0x8f0f
p 00000024 3829ffff  # xori  r9, r1, 0xffff
p 00000028 00225024  # and   r10, r1, r2
p 0000002c 01095825  # or    r11, r8, r9
p 00000030 01626026  # xor   r12, r11, r2
p 00000034 01806827  # nor   r13, r12, r0
p 00000038 00017100  # sll   r14, r1, 4
p 0000003c 00027f02  # srl   r15, r2, 28
p 00000040 24000007  # addiu r0, r0, 7          hidden write
p 00000044 00018021  # addu  r16, r0, r1
p 00000048 10a70003  # beq   r5, r7, 0x58       taken
p 0000004c 24140bad  # addiu r20, r0, 0xbad     flushed
p 00000050 24140bad
p 00000054 24140bad
p 00000058 14a60003  # bne   r5, r6, 0x68       taken
p 0000005c 24140bad
p 00000060 24140bad
p 00000064 24140bad
p 00000068 10a60001  # beq   r5, r6             not taken
p 0000006c 24110003  # addiu r17, r0, 3
p 00000070 14a70001  # bne   r5, r7             not taken
p 00000074 24120000  # addiu r18, r0, 0
p 00000078 26520005  # addiu r18, r18, 5        loop
p 0000007c 2631ffff  # addiu r17, r17, -1
p 00000080 1620fffd  # bne   r17, r0, 0x78      backward
p 00000084 08000025  # j     0x94
p 00000088 24140bad
p 0000008c 24140bad
p 00000090 24140bad
p 00000094 02519821  # addu  r19, r18, r17
p 00000098 fc000000  # halt
w 01 12340000
w 01 12348765
w 02 ffffffff
w 03 12348764
w 04 ffffffff
w 05 00000001
w 06 00000000
w 07 00000001
w 08 00008f0f
w 09 1234789a
w 0a 12348765
w 0b 1234ff9f
w 0c edcb0060
w 0d 1234ff9f
w 0e 23487650
w 0f 0000000f
w 10 12348765
w 11 00000003
w 12 00000000
w 12 00000005
w 11 00000002
w 12 0000000a
w 11 00000001
w 12 0000000f
w 11 00000000
w 13 0000000f

// ==== dv/pipe_cpu_tb.sv ====
module pipe_cpu_tb;
   timeunit 1ns;
   timeprecision 1ps;

   logic CLK;
   logic nRST;
   logic ihit;
   pipe_cpu_pkg::word_t imem_load;
   pipe_cpu_pkg::word_t imem_addr;
   logic wb_wen;
   pipe_cpu_pkg::regbits_t wb_wsel;
   pipe_cpu_pkg::word_t wb_wdat;
   logic halt;

   pipe_cpu_pkg::word_t imem [pipe_cpu_pkg::word_t];   // sparse, keyed by byte address
   pipe_cpu_pkg::regbits_t exp_reg [$];                // expected write trace
   pipe_cpu_pkg::word_t exp_val [$];
   int prog_lines;
   int exp_idx;      // next expected write
   int cycles;       // cycles since reset release
   int limit;
   int post_halt;    // cycles seen with halt high
   logic [31:0] rng;

   pipe_cpu i_dut (
      .CLK(CLK),
      .nRST(nRST),
      .imem_load(imem_load),
      .ihit(ihit),
      .imem_addr(imem_addr),
      .wb_wen(wb_wen),
      .wb_wsel(wb_wsel),
      .wb_wdat(wb_wdat),
      .halt(halt)
   );

   always #4 CLK = ~CLK;   // 8 ns period

   task automatic abort_run();
      $display("Result: FAILED");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic compare_regbits(input pipe_cpu_pkg::regbits_t got,
                                  input pipe_cpu_pkg::regbits_t want, input int n);
      if (got !== want)
      begin
         $display("FAILED at %0t: write %0d went to r%0d, expected r%0d", $time, n, got, want);
         abort_run();
      end
   endtask

   task automatic compare_word(input pipe_cpu_pkg::word_t got,
                               input pipe_cpu_pkg::word_t want, input int n);
      if (got !== want)
      begin
         $display("FAILED at %0t: write %0d data %h, expected %h", $time, n, got, want);
         abort_run();
      end
   endtask

   // 32-bit xorshift step
   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] x;
      x = s;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      return x;
   endfunction

   function automatic pipe_cpu_pkg::word_t fetch_word(input pipe_cpu_pkg::word_t addr);
      if (imem.exists(addr))
         return imem[addr];
      return '0;   // sll r0 nop past the program
   endfunction

   // p lines fill imem, w lines build the trace, anything else skipped
   task automatic read_stimulus();
      int fd;
      int cnt;
      string line;
      logic [7:0] kind;
      logic [31:0] a;
      logic [31:0] b;
      fd = $fopen("dv/pipe_cpu_stimulus.txt", "r");
      if (fd == 0)
      begin
         $display("Could not open dv/pipe_cpu_stimulus.txt for reading");
         abort_run();
      end
      while ($fgets(line, fd) != 0)
      begin
         cnt = $sscanf(line, "%c %h %h", kind, a, b);
         if (cnt == 3 && kind == "p")
         begin
            imem[a] = b;
            prog_lines++;
         end
         else if (cnt == 3 && kind == "w")
         begin
            exp_reg.push_back(pipe_cpu_pkg::regbits_t'(a));
            exp_val.push_back(b);
         end
      end
      $fclose(fd);
   endtask

   initial
   begin
      CLK = 1'b0;
      nRST = 1'b0;
      ihit = 1'b0;        // no fetch during reset
      imem_load = '0;
      rng = 32'd75;       // seed
      prog_lines = 0;
      exp_idx = 0;
      cycles = 0;
      post_halt = 0;
      read_stimulus();
      limit = 8 * (prog_lines + exp_reg.size()) + 200;
      repeat (16) @(negedge CLK);
      nRST = 1'b1;

      // watch 20 frozen cycles after halt before calling it done
      while (post_halt < 20)
      begin
         @(negedge CLK);
         cycles++;
         if (cycles > limit)
         begin
            $display("Timeout: halt and the full write trace not seen in %0d cycles", limit);
            abort_run();
         end
         rng = xorshift32(rng);
         ihit = (rng[1:0] != 2'b00);           // high about 3 cycles in 4
         imem_load = fetch_word(imem_addr);    // PC settled since the rising edge
         #2;                                   // outputs settle before the next edge
         if (wb_wen)
         begin
            if (exp_idx >= exp_reg.size())
            begin
               $display("Extra write to r%0d of %h after the whole trace was seen",
                        wb_wsel, wb_wdat);
               abort_run();
            end
            compare_regbits(wb_wsel, exp_reg[exp_idx], exp_idx);
            compare_word(wb_wdat, exp_val[exp_idx], exp_idx);
            exp_idx++;
         end
         if (halt)
         begin
            if (exp_idx != exp_reg.size())
            begin
               $display("Missing writes, halt rose after %0d of %0d expected writes",
                        exp_idx, exp_reg.size());
               abort_run();
            end
            post_halt++;
         end
         else if (post_halt != 0)
         begin
            $display("halt dropped again after it had risen");
            abort_run();
         end
      end
      $display("Result: PASSED");
      $finish;
   end

endmodule

// ==== hw/alu.sv ====
`include "pipe_cpu_defs.svh"

module alu
(
   input  pipe_cpu_pkg::aluop_t aluop,
   input  pipe_cpu_pkg::word_t port_a,
   input  pipe_cpu_pkg::word_t port_b,
   output pipe_cpu_pkg::word_t result,
   output logic zero
);
   logic lt_s;
   logic lt_u;

   assign lt_s = $signed(port_a) < $signed(port_b);
   assign lt_u = port_a < port_b;

   always_comb
   begin
      case (aluop)
         pipe_cpu_pkg::ALU_SLL:  result = port_b << port_a[`REG_W-1:0];   // shamt on a
         pipe_cpu_pkg::ALU_SRL:  result = port_b >> port_a[`REG_W-1:0];
         pipe_cpu_pkg::ALU_ADD:  result = port_a + port_b;
         pipe_cpu_pkg::ALU_SUB:  result = port_a - port_b;
         pipe_cpu_pkg::ALU_AND:  result = port_a & port_b;
         pipe_cpu_pkg::ALU_OR:   result = port_a | port_b;
         pipe_cpu_pkg::ALU_XOR:  result = port_a ^ port_b;
         pipe_cpu_pkg::ALU_NOR:  result = ~(port_a | port_b);
         pipe_cpu_pkg::ALU_SLT:  result = {{(`WORD_W-1){1'b0}}, lt_s};
         pipe_cpu_pkg::ALU_SLTU: result = {{(`WORD_W-1){1'b0}}, lt_u};
         pipe_cpu_pkg::ALU_LUI:  result = port_b << `IMM_W;   // imm to upper half
         default:                result = '0;
      endcase
   end

   assign zero = (result == '0);   // beq / bne test

endmodule

// ==== hw/decode_unit.sv ====
`include "pipe_cpu_defs.svh"

module decode_unit
(
   input  pipe_cpu_pkg::word_t instr,
   output pipe_cpu_pkg::ctrl_t ctrl
);
   pipe_cpu_pkg::opcode_t opcode;
   pipe_cpu_pkg::funct_t funct;

   assign opcode = pipe_cpu_pkg::opcode_t'(instr[`OPC_HI:`OPC_LO]);
   assign funct = pipe_cpu_pkg::funct_t'(instr[`FUNCT_HI:`FUNCT_LO]);

   always_comb
   begin
      ctrl = '0;   // nop unless matched below
      case (opcode)
         pipe_cpu_pkg::RTYPE:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.reg_dst = 1'b1;
            case (funct)
               pipe_cpu_pkg::SLL:
               begin
                  ctrl.aluop = pipe_cpu_pkg::ALU_SLL;
                  ctrl.shift_op = 1'b1;
               end
               pipe_cpu_pkg::SRL:
               begin
                  ctrl.aluop = pipe_cpu_pkg::ALU_SRL;
                  ctrl.shift_op = 1'b1;
               end
               pipe_cpu_pkg::ADDU: ctrl.aluop = pipe_cpu_pkg::ALU_ADD;
               pipe_cpu_pkg::SUBU: ctrl.aluop = pipe_cpu_pkg::ALU_SUB;
               pipe_cpu_pkg::AND:  ctrl.aluop = pipe_cpu_pkg::ALU_AND;
               pipe_cpu_pkg::OR:   ctrl.aluop = pipe_cpu_pkg::ALU_OR;
               pipe_cpu_pkg::XOR:  ctrl.aluop = pipe_cpu_pkg::ALU_XOR;
               pipe_cpu_pkg::NOR:  ctrl.aluop = pipe_cpu_pkg::ALU_NOR;
               pipe_cpu_pkg::SLT:  ctrl.aluop = pipe_cpu_pkg::ALU_SLT;
               pipe_cpu_pkg::SLTU: ctrl.aluop = pipe_cpu_pkg::ALU_SLTU;
               default:            ctrl.reg_write = 1'b0;   // unknown funct, nop
            endcase
         end
         pipe_cpu_pkg::ADDIU, pipe_cpu_pkg::SLTI:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src = 1'b1;
            ctrl.ext_op = 1'b1;   // signed imm
            ctrl.aluop = (opcode == pipe_cpu_pkg::SLTI) ? pipe_cpu_pkg::ALU_SLT
                                                         : pipe_cpu_pkg::ALU_ADD;
         end
         pipe_cpu_pkg::ANDI, pipe_cpu_pkg::ORI, pipe_cpu_pkg::XORI, pipe_cpu_pkg::LUI:
         begin
            ctrl.reg_write = 1'b1;
            ctrl.alu_src = 1'b1;   // zero extended
            case (opcode)
               pipe_cpu_pkg::ANDI: ctrl.aluop = pipe_cpu_pkg::ALU_AND;
               pipe_cpu_pkg::ORI:  ctrl.aluop = pipe_cpu_pkg::ALU_OR;
               pipe_cpu_pkg::XORI: ctrl.aluop = pipe_cpu_pkg::ALU_XOR;
               default:            ctrl.aluop = pipe_cpu_pkg::ALU_LUI;
            endcase
         end
         pipe_cpu_pkg::BEQ, pipe_cpu_pkg::BNE:
         begin
            ctrl.aluop = pipe_cpu_pkg::ALU_SUB;   // zero flag compares rs, rt
            ctrl.beq = (opcode == pipe_cpu_pkg::BEQ);
            ctrl.bne = (opcode == pipe_cpu_pkg::BNE);
         end
         pipe_cpu_pkg::J:    ctrl.jump = 1'b1;
         pipe_cpu_pkg::HALT: ctrl.halt = 1'b1;
         default:            ctrl = '0;
      endcase
   end

endmodule

// ==== hw/fetch_unit.sv ====
`include "pipe_cpu_defs.svh"

module fetch_unit
(
   input  logic CLK,
   input  logic nRST,
   input  logic ihit,
   input  logic halt,
   input  logic redirect,
   input  pipe_cpu_pkg::word_t redirect_pc,
   input  pipe_cpu_pkg::word_t imem_load,
   output pipe_cpu_pkg::word_t imem_addr,
   output pipe_cpu_pkg::word_t instr_d,
   output pipe_cpu_pkg::word_t pc_plus_4_d
);
   pipe_cpu_pkg::word_t pc;
   pipe_cpu_pkg::word_t pc_plus_4;
   logic adv;   // whole pipe moves

   assign adv = ihit && !halt;
   assign pc_plus_4 = pc + `PC_STEP;
   assign imem_addr = pc;

   // PC and IF/ID
   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         pc <= `PC_INIT;
         instr_d <= '0;     // sll r0 bubble
         pc_plus_4_d <= '0;
      end
      else if (adv)
      begin
         if (redirect)
         begin
            pc <= redirect_pc;   // taken branch or j in MEM
            instr_d <= '0;       // kill the word fetched this cycle
            pc_plus_4_d <= '0;
         end
         else
         begin
            pc <= pc_plus_4;
            instr_d <= imem_load;
            pc_plus_4_d <= pc_plus_4;
         end
      end
   end

   // word aligned fetch only
   assert property (@(posedge CLK) disable iff (!nRST) (pc % `PC_STEP) == '0);

endmodule

// ==== hw/forwarding_unit.sv ====
module forwarding_unit
(
   input  pipe_cpu_pkg::regbits_t rs_ex,
   input  pipe_cpu_pkg::regbits_t rt_ex,
   input  logic mem_wen,
   input  logic wb_wen,
   input  pipe_cpu_pkg::regbits_t mem_wsel,
   input  pipe_cpu_pkg::regbits_t wb_wsel,
   output pipe_cpu_pkg::fwd_sel_t fwd_a,
   output pipe_cpu_pkg::fwd_sel_t fwd_b
);
   // youngest producer wins, r0 never forwarded
   function automatic pipe_cpu_pkg::fwd_sel_t pick(input pipe_cpu_pkg::regbits_t src);
      pipe_cpu_pkg::fwd_sel_t sel;
      sel = pipe_cpu_pkg::FWD_REG;
      if (src != '0)
      begin
         if (mem_wen && mem_wsel == src)
            sel = pipe_cpu_pkg::FWD_MEM;
         else if (wb_wen && wb_wsel == src)
            sel = pipe_cpu_pkg::FWD_WB;
      end
      return sel;
   endfunction

   always_comb
   begin
      fwd_a = pick(rs_ex);
      fwd_b = pick(rt_ex);   // ignored when imm or shamt is used
   end

endmodule

// ==== hw/pipe_cpu.sv ====
`include "pipe_cpu_defs.svh"

module pipe_cpu
(
   input  logic CLK,
   input  logic nRST,
   input  pipe_cpu_pkg::word_t imem_load,
   input  logic ihit,
   output pipe_cpu_pkg::word_t imem_addr,
   output logic wb_wen,
   output pipe_cpu_pkg::regbits_t wb_wsel,
   output pipe_cpu_pkg::word_t wb_wdat,
   output logic halt
);
   logic adv;        // every stage moves this cycle
   logic redirect;   // taken branch or j in MEM
   pipe_cpu_pkg::word_t redirect_pc;
   pipe_cpu_pkg::word_t instr_d;
   pipe_cpu_pkg::word_t pc_plus_4_d;
   pipe_cpu_pkg::word_t rdat1;
   pipe_cpu_pkg::word_t rdat2;
   pipe_cpu_pkg::ctrl_t ctrl_d;
   pipe_cpu_pkg::id_ex_t id_ex;
   pipe_cpu_pkg::id_ex_t id_ex_d;
   pipe_cpu_pkg::ex_mem_t ex_mem;
   pipe_cpu_pkg::ex_mem_t ex_mem_d;
   pipe_cpu_pkg::mem_wb_t mem_wb;
   pipe_cpu_pkg::fwd_sel_t fwd_a;
   pipe_cpu_pkg::fwd_sel_t fwd_b;
   pipe_cpu_pkg::word_t rs_val;
   pipe_cpu_pkg::word_t rt_val;
   pipe_cpu_pkg::word_t imm_ext;
   pipe_cpu_pkg::word_t br_off;
   pipe_cpu_pkg::word_t port_a;
   pipe_cpu_pkg::word_t port_b;
   pipe_cpu_pkg::word_t alu_out;
   logic alu_zero;

   // a halt sitting in WB freezes everything, so halt stays up
   assign halt = mem_wb.halt;
   assign adv = ihit && !halt;

   fetch_unit u_fetch (
      .CLK(CLK), .nRST(nRST), .ihit(ihit), .halt(halt),
      .redirect(redirect), .redirect_pc(redirect_pc), .imem_load(imem_load),
      .imem_addr(imem_addr), .instr_d(instr_d), .pc_plus_4_d(pc_plus_4_d)
   );

   // decode
   decode_unit u_decode (.instr(instr_d), .ctrl(ctrl_d));

   register_file u_regs (
      .CLK(CLK), .nRST(nRST), .wen(wb_wen), .wsel(mem_wb.wsel), .wdat(mem_wb.result),
      .rsel1(instr_d[`RS_HI:`RS_LO]), .rsel2(instr_d[`RT_HI:`RT_LO]),
      .rdat1(rdat1), .rdat2(rdat2)
   );

   always_comb
   begin
      id_ex_d.ctrl = ctrl_d;
      id_ex_d.rdata1 = rdat1;
      id_ex_d.rdata2 = rdat2;
      id_ex_d.rs = instr_d[`RS_HI:`RS_LO];
      id_ex_d.rt = instr_d[`RT_HI:`RT_LO];
      id_ex_d.rd = instr_d[`RD_HI:`RD_LO];
      id_ex_d.imm = instr_d[`IMM_W-1:0];
      id_ex_d.shamt = instr_d[`SHAMT_HI:`SHAMT_LO];
      id_ex_d.jaddr = instr_d[`JADDR_W-1:0];
      id_ex_d.pc_plus_4 = pc_plus_4_d;
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         id_ex <= '0;
      else if (adv)
         id_ex <= redirect ? '0 : id_ex_d;   // flush -> bubble
   end

   // execute
   forwarding_unit u_fwd (
      .rs_ex(id_ex.rs), .rt_ex(id_ex.rt),
      .mem_wen(ex_mem.reg_write), .wb_wen(mem_wb.reg_write),
      .mem_wsel(ex_mem.wsel), .wb_wsel(mem_wb.wsel),
      .fwd_a(fwd_a), .fwd_b(fwd_b)
   );

   always_comb
   begin
      case (fwd_a)
         pipe_cpu_pkg::FWD_MEM: rs_val = ex_mem.result;
         pipe_cpu_pkg::FWD_WB:  rs_val = mem_wb.result;
         default:               rs_val = id_ex.rdata1;
      endcase
      case (fwd_b)
         pipe_cpu_pkg::FWD_MEM: rt_val = ex_mem.result;
         pipe_cpu_pkg::FWD_WB:  rt_val = mem_wb.result;
         default:               rt_val = id_ex.rdata2;
      endcase
   end

   assign imm_ext = id_ex.ctrl.ext_op
                    ? {{(`WORD_W-`IMM_W){id_ex.imm[`IMM_W-1]}}, id_ex.imm}
                    : {{(`WORD_W-`IMM_W){1'b0}}, id_ex.imm};
   assign port_a = id_ex.ctrl.shift_op ? pipe_cpu_pkg::word_t'(id_ex.shamt) : rs_val;
   assign port_b = id_ex.ctrl.alu_src ? imm_ext : rt_val;
   assign br_off = {{(`WORD_W-`IMM_W-2){id_ex.imm[`IMM_W-1]}}, id_ex.imm, 2'b00};

   alu u_alu (.aluop(id_ex.ctrl.aluop), .port_a(port_a), .port_b(port_b),
              .result(alu_out), .zero(alu_zero));

   always_comb
   begin
      ex_mem_d.reg_write = id_ex.ctrl.reg_write;
      ex_mem_d.beq = id_ex.ctrl.beq;
      ex_mem_d.bne = id_ex.ctrl.bne;
      ex_mem_d.jump = id_ex.ctrl.jump;
      ex_mem_d.halt = id_ex.ctrl.halt;
      ex_mem_d.result = alu_out;
      ex_mem_d.zero = alu_zero;
      ex_mem_d.wsel = id_ex.ctrl.reg_dst ? id_ex.rd : id_ex.rt;
      ex_mem_d.br_target = id_ex.pc_plus_4 + br_off;
      ex_mem_d.j_target = {id_ex.pc_plus_4[`WORD_W-1:`JADDR_W+2], id_ex.jaddr, 2'b00};
   end

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         ex_mem <= '0;
      else if (adv)
         ex_mem <= redirect ? '0 : ex_mem_d;
   end

   // memory: branches resolve here, predicted not taken
   assign redirect = ex_mem.jump || (ex_mem.beq && ex_mem.zero) || (ex_mem.bne && !ex_mem.zero);
   assign redirect_pc = ex_mem.jump ? ex_mem.j_target : ex_mem.br_target;

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
         mem_wb <= '0;
      else if (adv)
      begin
         mem_wb.reg_write <= ex_mem.reg_write;
         mem_wb.halt <= ex_mem.halt;
         mem_wb.wsel <= ex_mem.wsel;
         mem_wb.result <= ex_mem.result;
      end
   end

   // write-back, once per advancing cycle, r0 hidden
   assign wb_wen = adv && mem_wb.reg_write && (mem_wb.wsel != '0);
   assign wb_wsel = mem_wb.wsel;
   assign wb_wdat = mem_wb.result;

   // the frozen halt entry carries no register write
   assert property (@(posedge CLK) disable iff (!nRST) halt |-> !mem_wb.reg_write);

   // r0 operands stay zero past the forwarding muxes
   assert property (@(posedge CLK) disable iff (!nRST) (id_ex.rs == '0) |-> (rs_val == '0));
   assert property (@(posedge CLK) disable iff (!nRST) (id_ex.rt == '0) |-> (rt_val == '0));

   // opcode outside the subset decodes as a nop
   assert property (@(posedge CLK) disable iff (!nRST)
      adv |-> instr_d[`OPC_HI:`OPC_LO] inside {pipe_cpu_pkg::RTYPE, pipe_cpu_pkg::J,
         pipe_cpu_pkg::BEQ, pipe_cpu_pkg::BNE, pipe_cpu_pkg::ADDIU, pipe_cpu_pkg::SLTI,
         pipe_cpu_pkg::ANDI, pipe_cpu_pkg::ORI, pipe_cpu_pkg::XORI, pipe_cpu_pkg::LUI,
         pipe_cpu_pkg::HALT});

endmodule

// ==== hw/pipe_cpu_defs.svh ====
`ifndef PIPE_CPU_DEFS_SVH
`define PIPE_CPU_DEFS_SVH

// datapath widths
`define WORD_W 32
`define REG_W 5

`define PC_INIT 32'h0000_0000   // first fetch address
`define PC_STEP 32'd4           // bytes per instruction

// instruction fields
`define OPC_HI 31
`define OPC_LO 26
`define RS_HI 25
`define RS_LO 21
`define RT_HI 20
`define RT_LO 16
`define RD_HI 15
`define RD_LO 11
`define SHAMT_HI 10
`define SHAMT_LO 6
`define FUNCT_HI 5
`define FUNCT_LO 0
`define IMM_W 16     // low half of the word
`define JADDR_W 26   // j target field, word index

`endif

// ==== hw/pipe_cpu_pkg.sv ====
`include "pipe_cpu_defs.svh"

package pipe_cpu_pkg;

   typedef logic [`WORD_W-1:0] word_t;
   typedef logic [`REG_W-1:0] regbits_t;
   typedef logic [`IMM_W-1:0] imm_t;
   typedef logic [`SHAMT_HI-`SHAMT_LO:0] shamt_t;
   typedef logic [`JADDR_W-1:0] jaddr_t;

   // MIPS opcodes of the subset
   typedef enum logic [`OPC_HI-`OPC_LO:0] {
      RTYPE = 6'b000000,
      J     = 6'b000010,
      BEQ   = 6'b000100,
      BNE   = 6'b000101,
      ADDIU = 6'b001001,
      SLTI  = 6'b001010,
      ANDI  = 6'b001100,
      ORI   = 6'b001101,
      XORI  = 6'b001110,
      LUI   = 6'b001111,
      HALT  = 6'b111111
   } opcode_t;

   // R-type funct codes
   typedef enum logic [`FUNCT_HI-`FUNCT_LO:0] {
      SLL  = 6'b000000,
      SRL  = 6'b000010,
      ADDU = 6'b100001,
      SUBU = 6'b100011,
      AND  = 6'b100100,
      OR   = 6'b100101,
      XOR  = 6'b100110,
      NOR  = 6'b100111,
      SLT  = 6'b101010,
      SLTU = 6'b101011
   } funct_t;

   typedef enum logic [3:0] {
      ALU_SLL, ALU_SRL, ALU_ADD, ALU_SUB, ALU_AND, ALU_OR,
      ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU, ALU_LUI
   } aluop_t;   // ALU_SLL is 0, so an all-zero ctrl is a nop

   typedef enum logic [1:0] {
      FWD_REG, // value read in decode
      FWD_MEM, // EX/MEM result
      FWD_WB   // MEM/WB result
   } fwd_sel_t;

   typedef struct packed {
      logic reg_write;
      logic reg_dst;   // rd, else rt
      logic alu_src;   // immediate on port b
      logic ext_op;    // sign extend imm
      logic shift_op;  // shamt on port a
      logic beq;
      logic bne;
      logic jump;
      logic halt;
      aluop_t aluop;
   } ctrl_t;

   typedef struct packed {
      ctrl_t ctrl;
      word_t rdata1;
      word_t rdata2;
      regbits_t rs;
      regbits_t rt;
      regbits_t rd;
      imm_t imm;
      shamt_t shamt;
      jaddr_t jaddr;
      word_t pc_plus_4;
   } id_ex_t;

   typedef struct packed {
      logic reg_write;
      logic beq;
      logic bne;
      logic jump;
      logic halt;
      word_t result;
      logic zero;
      regbits_t wsel;
      word_t br_target;
      word_t j_target;
   } ex_mem_t;

   typedef struct packed {
      logic reg_write;
      logic halt;
      regbits_t wsel;
      word_t result;
   } mem_wb_t;

endpackage

// ==== hw/register_file.sv ====
module register_file
(
   input  logic CLK,
   input  logic nRST,
   input  logic wen,
   input  pipe_cpu_pkg::regbits_t wsel,
   input  pipe_cpu_pkg::word_t wdat,
   input  pipe_cpu_pkg::regbits_t rsel1,
   input  pipe_cpu_pkg::regbits_t rsel2,
   output pipe_cpu_pkg::word_t rdat1,
   output pipe_cpu_pkg::word_t rdat2
);
   pipe_cpu_pkg::word_t regs [1:31];   // r0 has no storage

   always_ff @(posedge CLK, negedge nRST)
   begin
      if (!nRST)
      begin
         for (int i = 1; i < 32; i++)
            regs[i] <= '0;
      end
      else if (wen && wsel != '0)
         regs[wsel] <= wdat;
   end

   // write-through so WB and ID can share a cycle
   assign rdat1 = (rsel1 == '0) ? '0 : (wen && wsel == rsel1) ? wdat : regs[rsel1];
   assign rdat2 = (rsel2 == '0) ? '0 : (wen && wsel == rsel2) ? wdat : regs[rsel2];

endmodule

// ==== pipe_cpu.f ====
+incdir+hw
hw/pipe_cpu_pkg.sv
hw/fetch_unit.sv
hw/decode_unit.sv
hw/register_file.sv
hw/alu.sv
hw/forwarding_unit.sv
hw/pipe_cpu.sv
dv/pipe_cpu_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run pipe_cpu_tb with Verilator, from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
   --top-module pipe_cpu_tb \
   -f pipe_cpu.f \
   --Mdir obj_dir -o pipe_cpu_sim
if [ $? -ne 0 ]; then
   echo "Verilator build failed"
   exit 1
fi

./obj_dir/pipe_cpu_sim > sim.log 2>&1
sim_status=$?
cat sim.log
if [ $sim_status -ne 0 ]; then
   echo "simulation exited with status $sim_status"
   exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
   exit 0
else
   echo "pass line not found in sim.log"
   exit 1
fi
